//--- verilog/rv32_pkg.sv
package rv32_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;
    localparam int OPC_W     = 7;

    typedef logic [WORD_W-1:0]    word_t;    // Data, pc or immediate
    typedef logic [REG_IDX_W-1:0] reg_idx_t; // Register index

    // Major opcodes of the supported classes
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

    // ******************************
    // Selectors
    // ******************************
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // LUI
    } alu_op_t;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_t;

    typedef enum logic {MUX1_RS1, MUX1_PC} alumux1_sel_t;

    typedef enum logic [2:0] {
        MUX2_RS2,
        MUX2_I_IMM,
        MUX2_S_IMM,
        MUX2_B_IMM,
        MUX2_U_IMM,
        MUX2_J_IMM
    } alumux2_sel_t;

    typedef enum logic {CMPMUX_RS2, CMPMUX_I_IMM} cmpmux_sel_t;

    typedef enum logic [1:0] {FWD_RF, FWD_EXE, FWD_RES} fwd_sel_t;

    // ******************************
    // Stage payloads
    // ******************************
    typedef struct packed {
        word_t i;
        word_t s;
        word_t b;
        word_t u;
        word_t j;
    } imm_set_t;

    typedef struct packed {
        alu_op_t      aluop;
        cmp_op_t      cmpop;
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmpmux_sel_t  cmp_sel;
        fwd_sel_t     rs1_sel;
        fwd_sel_t     rs2_sel;
        logic         reg_we;
        logic         is_branch;
        logic         illegal;
        reg_idx_t     rd;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        imm_set_t   imm;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      pc;
    } dec_exe_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     reg_we;
        logic     is_branch;
        logic     illegal;
        word_t    alu_out;  // Result, or branch target
        logic     br_en;
        word_t    pc;
    } exe_res_t;

    typedef exe_res_t retire_t;

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  rv32_pkg::reg_idx_t rs1_idx_i,
    input  rv32_pkg::reg_idx_t rs2_idx_i,
    input  logic               we_i,
    input  rv32_pkg::reg_idx_t rd_idx_i,
    input  rv32_pkg::word_t    rd_data_i,
    output rv32_pkg::word_t    rs1_data_o,
    output rv32_pkg::word_t    rs2_data_o
);

    rv32_pkg::word_t regs [rv32_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rv32_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_idx_i != '0)) begin // x0 is never written
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // Asynchronous read ports
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv32_pkg::alu_op_t aluop_i,
    input  rv32_pkg::word_t   a_i,
    input  rv32_pkg::word_t   b_i,
    output rv32_pkg::word_t   f_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (aluop_i)
            rv32_pkg::ALU_ADD:    f_o = a_i + b_i;
            rv32_pkg::ALU_SUB:    f_o = a_i - b_i;
            rv32_pkg::ALU_SLL:    f_o = a_i << shamt;
            rv32_pkg::ALU_SLT:    f_o = {{(rv32_pkg::WORD_W-1){1'b0}}, lt_s};
            rv32_pkg::ALU_SLTU:   f_o = {{(rv32_pkg::WORD_W-1){1'b0}}, lt_u};
            rv32_pkg::ALU_XOR:    f_o = a_i ^ b_i;
            rv32_pkg::ALU_SRL:    f_o = a_i >> shamt;
            rv32_pkg::ALU_SRA:    f_o = $signed(a_i) >>> shamt; // Sign fill
            rv32_pkg::ALU_OR:     f_o = a_i | b_i;
            rv32_pkg::ALU_AND:    f_o = a_i & b_i;
            rv32_pkg::ALU_PASS_B: f_o = b_i;
            default:              f_o = '0;
        endcase
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    input  logic                 instr_valid_i,
    input  rv32_pkg::word_t      instr_i,
    input  rv32_pkg::word_t      pc_i,
    input  rv32_pkg::word_t      rf_rs1_i,
    input  rv32_pkg::word_t      rf_rs2_i,
    output rv32_pkg::reg_idx_t   rs1_idx_o,
    output rv32_pkg::reg_idx_t   rs2_idx_o,
    output logic                 dx_valid_o,
    output rv32_pkg::dec_exe_t   dx_o
);

    logic [rv32_pkg::OPC_W-1:0] opcode;
    logic [2:0]                 funct3;
    logic                       funct7_b5;
    rv32_pkg::imm_set_t         imm;
    rv32_pkg::ctrl_word_t       ctrl;
    rv32_pkg::reg_idx_t         prev_rd;   // Destination now in the result register path
    logic                       prev_we;
    logic                       exe_live;
    logic                       res_live;

    function automatic rv32_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
            3'b001:  return rv32_pkg::ALU_SLL;
            3'b010:  return rv32_pkg::ALU_SLT;
            3'b011:  return rv32_pkg::ALU_SLTU;
            3'b100:  return rv32_pkg::ALU_XOR;
            3'b101:  return alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
            3'b110:  return rv32_pkg::ALU_OR;
            default: return rv32_pkg::ALU_AND;
        endcase
    endfunction

    // Nearer producer wins
    function automatic rv32_pkg::fwd_sel_t fwd_pick(input rv32_pkg::reg_idx_t src);
        if (exe_live && (dx_o.ctrl.rd == src)) begin
            return rv32_pkg::FWD_EXE;
        end else if (res_live && (prev_rd == src)) begin
            return rv32_pkg::FWD_RES;
        end
        return rv32_pkg::FWD_RF;
    endfunction

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    assign exe_live = dx_valid_o && dx_o.ctrl.reg_we && (dx_o.ctrl.rd != '0);
    assign res_live = prev_we && (prev_rd != '0);

    // ******************************
    // Immediates
    // ******************************
    assign imm.i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm.s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm.b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm.u = {instr_i[31:12], 12'h000};
    assign imm.j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // ******************************
    // Control word
    // ******************************
    always_comb begin
        ctrl             = '0;
        ctrl.aluop       = rv32_pkg::ALU_ADD;
        ctrl.cmpop       = rv32_pkg::CMP_BEQ;
        ctrl.alumux1_sel = rv32_pkg::MUX1_RS1;
        ctrl.alumux2_sel = rv32_pkg::MUX2_RS2;
        ctrl.cmp_sel     = rv32_pkg::CMPMUX_RS2;
        ctrl.rd          = instr_i[11:7];
        case (opcode)
            rv32_pkg::OPC_OP: begin
                ctrl.reg_we = 1'b1;
                ctrl.aluop  = alu_sel(funct3, funct7_b5);
            end
            rv32_pkg::OPC_OP_IMM: begin
                ctrl.reg_we      = 1'b1;
                ctrl.alumux2_sel = rv32_pkg::MUX2_I_IMM;
                ctrl.aluop       = alu_sel(funct3, (funct3 == 3'b101) && funct7_b5); // No subi
            end
            rv32_pkg::OPC_LUI: begin
                ctrl.reg_we      = 1'b1;
                ctrl.alumux2_sel = rv32_pkg::MUX2_U_IMM;
                ctrl.aluop       = rv32_pkg::ALU_PASS_B;
            end
            rv32_pkg::OPC_AUIPC: begin
                ctrl.reg_we      = 1'b1;
                ctrl.alumux1_sel = rv32_pkg::MUX1_PC;
                ctrl.alumux2_sel = rv32_pkg::MUX2_U_IMM;
            end
            rv32_pkg::OPC_BRANCH: begin
                ctrl.is_branch   = 1'b1;
                ctrl.alumux1_sel = rv32_pkg::MUX1_PC;  // Target is pc + B imm
                ctrl.alumux2_sel = rv32_pkg::MUX2_B_IMM;
                ctrl.cmpop       = rv32_pkg::cmp_op_t'(funct3);
            end
            default: ctrl.illegal = 1'b1;
        endcase
        ctrl.rs1_sel = fwd_pick(rs1_idx_o);
        ctrl.rs2_sel = fwd_pick(rs2_idx_o);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dx_valid_o <= 1'b0;
            prev_we    <= 1'b0;
        end else if (!stall_i) begin
            dx_valid_o <= instr_valid_i;
            prev_we    <= dx_valid_o && dx_o.ctrl.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            dx_o.ctrl     <= ctrl;
            dx_o.imm      <= imm;
            dx_o.rs1_data <= rf_rs1_i;
            dx_o.rs2_data <= rf_rs2_i;
            dx_o.pc       <= pc_i;
            prev_rd       <= dx_o.ctrl.rd;
        end
    end

endmodule

//--- verilog/exe_stage.sv
`timescale 1ns/1ns

module exe_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    input  logic                 dx_valid_i,
    input  rv32_pkg::dec_exe_t   dx_i,
    input  rv32_pkg::word_t      res_fwd_data_i,
    output rv32_pkg::word_t      exe_fwd_data_o,
    output logic                 xr_valid_o,
    output rv32_pkg::exe_res_t   xr_o
);

    rv32_pkg::word_t rs1_val;
    rv32_pkg::word_t rs2_val;
    rv32_pkg::word_t alumux1_out;
    rv32_pkg::word_t alumux2_out;
    rv32_pkg::word_t cmpmux_out;
    rv32_pkg::word_t alu_f;
    logic            cmp_true;

    function automatic rv32_pkg::word_t operand(input rv32_pkg::fwd_sel_t sel,
                                                input rv32_pkg::word_t  rf_val);
        case (sel)
            rv32_pkg::FWD_EXE: return exe_fwd_data_o;
            rv32_pkg::FWD_RES: return res_fwd_data_i;
            default:           return rf_val;
        endcase
    endfunction

    assign exe_fwd_data_o = xr_o.alu_out;

    // ******************************
    // Operand muxes
    // ******************************
    always_comb begin
        rs1_val = operand(dx_i.ctrl.rs1_sel, dx_i.rs1_data);
        rs2_val = operand(dx_i.ctrl.rs2_sel, dx_i.rs2_data);

        alumux1_out = (dx_i.ctrl.alumux1_sel == rv32_pkg::MUX1_PC) ? dx_i.pc : rs1_val;
        cmpmux_out  = (dx_i.ctrl.cmp_sel == rv32_pkg::CMPMUX_I_IMM) ? dx_i.imm.i : rs2_val;

        case (dx_i.ctrl.alumux2_sel)
            rv32_pkg::MUX2_I_IMM: alumux2_out = dx_i.imm.i;
            rv32_pkg::MUX2_S_IMM: alumux2_out = dx_i.imm.s;
            rv32_pkg::MUX2_B_IMM: alumux2_out = dx_i.imm.b;
            rv32_pkg::MUX2_U_IMM: alumux2_out = dx_i.imm.u;
            rv32_pkg::MUX2_J_IMM: alumux2_out = dx_i.imm.j;
            default:              alumux2_out = rs2_val;
        endcase
    end

    // Branch comparator
    always_comb begin
        case (dx_i.ctrl.cmpop)
            rv32_pkg::CMP_BEQ:  cmp_true = rs1_val == cmpmux_out;
            rv32_pkg::CMP_BNE:  cmp_true = rs1_val != cmpmux_out;
            rv32_pkg::CMP_BLT:  cmp_true = $signed(rs1_val) < $signed(cmpmux_out);
            rv32_pkg::CMP_BGE:  cmp_true = $signed(rs1_val) >= $signed(cmpmux_out);
            rv32_pkg::CMP_BLTU: cmp_true = rs1_val < cmpmux_out;
            rv32_pkg::CMP_BGEU: cmp_true = rs1_val >= cmpmux_out;
            default:            cmp_true = 1'b0;
        endcase
    end

    alu i_alu (
        .aluop_i (dx_i.ctrl.aluop),
        .a_i     (alumux1_out),
        .b_i     (alumux2_out),
        .f_o     (alu_f)
    );

    // ******************************
    // Execute to result register
    // ******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            xr_valid_o <= dx_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            xr_o.rd        <= dx_i.ctrl.rd;
            xr_o.reg_we    <= dx_i.ctrl.reg_we;
            xr_o.is_branch <= dx_i.ctrl.is_branch;
            xr_o.illegal   <= dx_i.ctrl.illegal;
            xr_o.alu_out   <= alu_f;
            xr_o.br_en     <= dx_i.ctrl.is_branch && cmp_true; // Low for non-branches
            xr_o.pc        <= dx_i.pc;
        end
    end

endmodule

//--- verilog/result_stage.sv
`timescale 1ns/1ns

module result_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    input  logic                 xr_valid_i,
    input  rv32_pkg::exe_res_t   xr_i,
    output logic                 rf_we_o,
    output rv32_pkg::reg_idx_t   rf_idx_o,
    output rv32_pkg::word_t      rf_data_o,
    output rv32_pkg::word_t      res_fwd_data_o,
    output logic                 ret_valid_o,
    output rv32_pkg::retire_t    ret_o
);

    logic load;

    assign load = !stall_i;

    // Write-back on the same edge that loads the retire register
    assign rf_we_o   = xr_valid_i && xr_i.reg_we && load;
    assign rf_idx_o  = xr_i.rd;
    assign rf_data_o = xr_i.alu_out;

    assign res_fwd_data_o = ret_o.alu_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ret_valid_o <= 1'b0;
        end else if (load) begin
            ret_valid_o <= xr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ret_o <= xr_i;
        end
    end

endmodule

//--- verilog/int_core_top.sv
`timescale 1ns/1ns

module int_core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid_i,
    input  rv32_pkg::word_t     instr_i,
    input  rv32_pkg::word_t     pc_i,
    output logic                instr_ready_o,
    input  logic                ret_ready_i,
    output logic                ret_valid_o,
    output rv32_pkg::retire_t   ret_o
);

    logic               stall;
    rv32_pkg::reg_idx_t rs1_idx;
    rv32_pkg::reg_idx_t rs2_idx;
    rv32_pkg::word_t    rf_rs1;
    rv32_pkg::word_t    rf_rs2;
    logic               rf_we;
    rv32_pkg::reg_idx_t rf_idx;
    rv32_pkg::word_t    rf_data;
    logic               dx_valid;
    rv32_pkg::dec_exe_t dx;
    logic               xr_valid;
    rv32_pkg::exe_res_t xr;
    rv32_pkg::word_t    res_fwd_data;

    // Consumer back-pressure freezes every stage
    assign stall         = ret_valid_o && !ret_ready_i;
    assign instr_ready_o = !stall;

    reg_file i_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .we_i       (rf_we),
        .rd_idx_i   (rf_idx),
        .rd_data_i  (rf_data),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    decode_stage i_decode_stage (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .instr_valid_i (instr_valid_i && instr_ready_o),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_rs1_i      (rf_rs1),
        .rf_rs2_i      (rf_rs2),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .dx_valid_o    (dx_valid),
        .dx_o          (dx)
    );

    exe_stage i_exe_stage (
        .clk            (clk),
        .rst            (rst),
        .stall_i        (stall),
        .dx_valid_i     (dx_valid),
        .dx_i           (dx),
        .res_fwd_data_i (res_fwd_data),
        .exe_fwd_data_o (),             // Only used inside the stage
        .xr_valid_o     (xr_valid),
        .xr_o           (xr)
    );

    result_stage i_result_stage (
        .clk            (clk),
        .rst            (rst),
        .stall_i        (stall),
        .xr_valid_i     (xr_valid),
        .xr_i           (xr),
        .rf_we_o        (rf_we),
        .rf_idx_o       (rf_idx),
        .rf_data_o      (rf_data),
        .res_fwd_data_o (res_fwd_data),
        .ret_valid_o    (ret_valid_o),
        .ret_o          (ret_o)
    );

endmodule

//--- testbench/tb_int_core.sv
`timescale 1ns/1ns

module tb_int_core;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = 4 * NUM_INSTR + 100;

    typedef struct packed {
        rv32_pkg::retire_t r;
        logic              chk_rd;   // Branch and illegal words carry no real rd
        logic              chk_alu;
    } expect_t;

    logic              clk;
    logic              rst;
    logic              instr_valid_i;
    rv32_pkg::word_t   instr_i;
    rv32_pkg::word_t   pc_i;
    logic              instr_ready_o;
    logic              ret_ready_i;
    logic              ret_valid_o;
    rv32_pkg::retire_t ret_o;

    int                seed = 18;
    rv32_pkg::word_t   model_regs [32];
    expect_t           exp_q [$];
    rv32_pkg::word_t   pc_next;
    rv32_pkg::retire_t held_ret;
    logic              accepted;
    logic              stalled;
    int                n_issued;
    int                n_acc;
    int                n_ret;
    int                cycles;
    int                value_errs;
    int                proto_errs;
    int                timeout_errs;

    int_core_top i_int_core_top (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_ready_o (instr_ready_o),
        .ret_ready_i   (ret_ready_i),
        .ret_valid_o   (ret_valid_o),
        .ret_o         (ret_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned pick_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // ******************************
    // Reference model
    // ******************************
    function automatic rv32_pkg::word_t alu_result(input logic [2:0] f3, input logic alt,
                                                   input rv32_pkg::word_t a,
                                                   input rv32_pkg::word_t b);
        rv32_pkg::word_t r;
        case (f3)
            3'b000: r = alt ? (a - b) : (a + b);
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];  // Sign fill
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv32_pkg::word_t a,
                                          input rv32_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Runs at acceptance, in program order
    task automatic predict(input rv32_pkg::word_t ins, input rv32_pkg::word_t pc);
        expect_t         e;
        rv32_pkg::word_t a;
        rv32_pkg::word_t b;
        rv32_pkg::word_t imm_i;
        rv32_pkg::word_t imm_b;
        rv32_pkg::word_t imm_u;
        logic [2:0]      f3;
        a         = model_regs[ins[19:15]];
        b         = model_regs[ins[24:20]];
        f3        = ins[14:12];
        imm_i     = {{20{ins[31]}}, ins[31:20]};
        imm_b     = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u     = {ins[31:12], 12'h000};
        e         = '0;
        e.r.pc    = pc;
        e.r.rd    = ins[11:7];
        e.chk_rd  = 1'b1;
        e.chk_alu = 1'b1;
        case (ins[6:0])
            rv32_pkg::OPC_OP: begin
                e.r.reg_we  = 1'b1;
                e.r.alu_out = alu_result(f3, ins[30], a, b);
            end
            rv32_pkg::OPC_OP_IMM: begin
                e.r.reg_we  = 1'b1;
                e.r.alu_out = alu_result(f3, (f3 == 3'b101) && ins[30], a, imm_i);
            end
            rv32_pkg::OPC_LUI: begin
                e.r.reg_we  = 1'b1;
                e.r.alu_out = imm_u;
            end
            rv32_pkg::OPC_AUIPC: begin
                e.r.reg_we  = 1'b1;
                e.r.alu_out = pc + imm_u;
            end
            rv32_pkg::OPC_BRANCH: begin
                e.r.is_branch = 1'b1;
                e.r.alu_out   = pc + imm_b;
                e.r.br_en     = branch_taken(f3, a, b);
                e.chk_rd      = 1'b0;
            end
            default: begin
                e.r.illegal = 1'b1;
                e.chk_rd    = 1'b0;
                e.chk_alu   = 1'b0;
            end
        endcase
        if (e.r.reg_we && (e.r.rd != 5'd0)) begin
            model_regs[e.r.rd] = e.r.alu_out;
        end
        exp_q.push_back(e);
    endtask

    // ******************************
    // Stimulus
    // ******************************
    task automatic build_instr(output rv32_pkg::word_t ins);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  shamt;
        logic [2:0]  f3;
        logic        alt;
        logic [6:0]  funct7;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic [6:0]  opc;
        int unsigned kind;
        rd     = 5'(pick_below(8));  // x0..x7 keeps hazards frequent
        rs1    = 5'(pick_below(8));
        rs2    = 5'(pick_below(8));
        shamt  = 5'(pick_below(32));
        f3     = 3'(pick_below(8));
        alt    = pick_below(2) == 0;
        funct7 = alt ? 7'h20 : 7'h00;
        kind   = pick_below(20);
        if (kind < 6) begin
            if ((f3 != 3'b000) && (f3 != 3'b101)) funct7 = 7'h00;
            ins = {funct7, rs2, rs1, f3, rd, rv32_pkg::OPC_OP};
        end else if (kind < 11) begin
            case (pick_below(8))
                0:       imm12 = 12'h7ff;
                1:       imm12 = 12'h800;
                2:       imm12 = 12'hfff;
                default: imm12 = 12'($random(seed));
            endcase
            if (f3 == 3'b001) imm12 = {7'h00, shamt};
            if (f3 == 3'b101) imm12 = {funct7, shamt};
            ins = {imm12, rs1, f3, rd, rv32_pkg::OPC_OP_IMM};
        end else if (kind < 14) begin
            case (pick_below(8))
                0:       upper = 20'h80000;  // Signed edge values
                1:       upper = 20'h7ffff;
                2:       upper = 20'hfffff;
                3:       upper = 20'h00000;
                default: upper = 20'($random(seed));
            endcase
            ins = {upper, rd, rv32_pkg::OPC_LUI};
        end else if (kind < 15) begin
            ins = {20'($random(seed)), rd, rv32_pkg::OPC_AUIPC};
        end else if (kind < 19) begin
            f3 = 3'(pick_below(6));
            if (f3 > 3'd1) f3 = f3 + 3'd2;  // Skip 010 and 011
            ins        = $random(seed);
            ins[6:0]   = rv32_pkg::OPC_BRANCH;
            ins[14:12] = f3;
            ins[19:15] = rs1;
            ins[24:20] = rs2;
        end else begin
            opc = 7'($random(seed));
            while (opc inside {rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM, rv32_pkg::OPC_LUI,
                               rv32_pkg::OPC_AUIPC, rv32_pkg::OPC_BRANCH}) begin
                opc = 7'($random(seed));
            end
            ins      = $random(seed);
            ins[6:0] = opc;
        end
    endtask

    task automatic drive_cycle;
        if (!instr_valid_i || accepted) begin
            if ((n_issued < NUM_INSTR) && (pick_below(4) != 0)) begin
                build_instr(instr_i);
                pc_i          = pc_next;
                pc_next       = pc_next + 32'd4;
                instr_valid_i = 1'b1;
                n_issued++;
            end else begin
                instr_valid_i = 1'b0;
            end
        end
        ret_ready_i = pick_below(4) != 0;
    endtask

    // ******************************
    // Checks
    // ******************************
    task automatic check_field(input string name, input rv32_pkg::word_t got,
                               input rv32_pkg::word_t exp);
        assert (got === exp) else begin
            $display("** Error %s: expected %h, got %h", name, exp, got);
            value_errs++;
        end
    endtask

    task automatic compare_retire(input rv32_pkg::retire_t got);
        expect_t e;
        assert (exp_q.size() > 0) else begin
            $display("A retirement appeared with no accepted instruction outstanding");
            proto_errs++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_field("ret_o.pc", got.pc, e.r.pc);  // Also proves ordering
            check_field("ret_o.reg_we", rv32_pkg::word_t'(got.reg_we),
                        rv32_pkg::word_t'(e.r.reg_we));
            check_field("ret_o.is_branch", rv32_pkg::word_t'(got.is_branch),
                        rv32_pkg::word_t'(e.r.is_branch));
            check_field("ret_o.illegal", rv32_pkg::word_t'(got.illegal),
                        rv32_pkg::word_t'(e.r.illegal));
            check_field("ret_o.br_en", rv32_pkg::word_t'(got.br_en),
                        rv32_pkg::word_t'(e.r.br_en));
            if (e.chk_rd) begin
                check_field("ret_o.rd", rv32_pkg::word_t'(got.rd), rv32_pkg::word_t'(e.r.rd));
            end
            if (e.chk_alu) begin
                check_field("ret_o.alu_out", got.alu_out, e.r.alu_out);
            end
        end
    endtask

    // Sampled at the falling edge, for the rising edge that follows
    task automatic sample_cycle;
        if (stalled) begin
            assert (ret_valid_o && (ret_o === held_ret)) else begin
                $display("** Error ret_o: held %h, now %h under back-pressure", held_ret, ret_o);
                value_errs++;
            end
        end
        stalled = ret_valid_o && !ret_ready_i;
        held_ret = ret_o;
        assert (instr_ready_o === !stalled) else begin
            $display("** Error instr_ready_o: expected %h, got %h", !stalled, instr_ready_o);
            proto_errs++;
        end
        if (ret_valid_o && ret_ready_i) begin
            compare_retire(ret_o);
            n_ret++;
        end
        accepted = instr_valid_i && instr_ready_o;
        if (accepted) begin
            predict(instr_i, pc_i);
            n_acc++;
        end
    endtask

    initial begin
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        ret_ready_i   = 1'b0;
        model_regs    = '{default: '0};
        pc_next       = 32'h0000_1000;
        held_ret      = '0;
        accepted      = 1'b0;
        stalled       = 1'b0;
        n_issued      = 0;
        n_acc         = 0;
        n_ret         = 0;
        cycles        = 0;
        value_errs    = 0;
        proto_errs    = 0;
        timeout_errs  = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (ret_valid_o === 1'b0) else begin
            $display("** Error ret_valid_o: expected 0, got %h after reset", ret_valid_o);
            proto_errs++;
        end
        assert (instr_ready_o === 1'b1) else begin
            $display("** Error instr_ready_o: expected 1, got %h after reset", instr_ready_o);
            proto_errs++;
        end
        @(posedge clk);
        #2;
        while (((n_acc < NUM_INSTR) || (n_ret < NUM_INSTR)) && (cycles < MAX_CYCLES)) begin
            drive_cycle;
            @(negedge clk);
            cycles++;
            sample_cycle;
            @(posedge clk);
            #2;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, n_ret, NUM_INSTR);
            timeout_errs++;
        end
        assert ((n_ret == n_acc) && (exp_q.size() == 0)) else begin
            $display("Accepted %0d instructions but retired %0d", n_acc, n_ret);
            proto_errs++;
        end
        $display("Errors: %0d value, %0d handshake, %0d timeout",
                 value_errs, proto_errs, timeout_errs);
        if ((value_errs + proto_errs + timeout_errs) == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/rv32_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/exe_stage.sv
verilog/result_stage.sv
verilog/int_core_top.sv
testbench/tb_int_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the integer pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_int_core \
    -f flist.f \
    --Mdir obj_dir \
    -o sim_tb_int_core

./obj_dir/sim_tb_int_core | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Run reported failure"
    exit 1
fi

echo "Run finished without failure"
